// ==== tb.f ====
+incdir+verilog
verilog/dinersPkg.sv
verilog/philosopher.sv
verilog/philRing.sv
verilog/tableController.sv
verilog/starvationMonitor.sv
verilog/mealCounter.sv
verilog/dinersTop.sv
verif/diners_assertions.sv
verif/dinersTb.sv

// ==== verif/dinersTb.sv ====
/*
 * Directed testbench for dinersTop with a cycle level reference model.
 * Each test is a task; the model advances together with the DUT in tick.
 */
`timescale 1ns/1ps
`include "diners_params.svh"

module dinersTb import dinersPkg::*;;

	logic clk;
	logic arstN;
	logic start;
	logic stop;
	logic clear;
	logic [`NUM_PHIL-1:0] hungryReq;
	logic [`NUM_PHIL-1:0] doneEat;
	philIdx mealSel;
	logic [2*`NUM_PHIL-1:0] philStates;
	logic running;
	logic halted;
	logic starving;
	philIdx starveIdx;
	mealCount mealCountOut;

	// reference model state
	philState mPhil [`NUM_PHIL];
	ctrlState mCtrl;
	int       mWait [`NUM_PHIL];
	logic     mStarving;
	int       mIdx;
	int       mMeals [`NUM_PHIL];
	logic     mPending [`NUM_PHIL];
	integer   seed;
	int       cycle;

	dinersTop dut0 (
		.clk          (clk),
		.arstN        (arstN),
		.start        (start),
		.stop         (stop),
		.clear        (clear),
		.hungryReq    (hungryReq),
		.doneEat      (doneEat),
		.mealSel      (mealSel),
		.philStates   (philStates),
		.running      (running),
		.halted       (halted),
		.starving     (starving),
		.starveIdx    (starveIdx),
		.mealCountOut (mealCountOut)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic checkVal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	function automatic logic [2*`NUM_PHIL-1:0] modelStates();
		logic [2*`NUM_PHIL-1:0] v;
		for (int i = 0; i < `NUM_PHIL; i++) begin
			v[2*i +: 2] = mPhil[i];
		end
		return v;
	endfunction

	task automatic modelReset();
		for (int i = 0; i < `NUM_PHIL; i++) begin
			mPhil[i] = (i == 0) ? READING : THINKING;
			mWait[i] = 0;
			mMeals[i] = 0;
			mPending[i] = 1'b0;
		end
		mCtrl = IDLE;
		mStarving = 1'b0;
		mIdx = 0;
	endtask

	task automatic compareAll();
		philState a;
		philState b;
		checkVal("philStates", philStates, modelStates());
		checkVal("running", running, mCtrl == RUN);
		checkVal("halted", halted, mCtrl == HALTED);
		checkVal("starving", starving, mStarving);
		checkVal("starveIdx", starveIdx, mIdx);
		checkVal("mealCountOut", mealCountOut, mealCount'(mMeals[mealSel]));
		for (int i = 0; i < `NUM_PHIL; i++) begin
			a = philState'(philStates[2*i +: 2]);
			b = philState'(philStates[2*((i + 1) % `NUM_PHIL) +: 2]);
			assert (!(a == EATING && b == EATING)) else begin
				$display("two adjacent philosophers are eating at cycle %0d", cycle);
				$display("STATUS: FAIL");
				$fatal(1);
			end
		end
		assert (dut0.dinersChk.failCount == 0) else begin
			$display("a concurrent assertion in the bound checker failed at cycle %0d", cycle);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	// one clock cycle for DUT and model, inputs as they stand before the edge
	task automatic tick();
		philState nPhil [`NUM_PHIL];
		philState lft;
		philState rgt;
		logic stepNow;
		logic clr;
		int hitIdx;
		stepNow = (mCtrl == RUN);
		clr = (mCtrl == IDLE && start) || (mCtrl == HALTED && clear);
		hitIdx = -1;
		for (int i = 0; i < `NUM_PHIL; i++) begin
			lft = mPhil[(i + 1) % `NUM_PHIL];
			rgt = mPhil[(i + `NUM_PHIL - 1) % `NUM_PHIL];
			nPhil[i] = mPhil[i];
			if (stepNow) begin
				if (mPhil[i] == READING && lft == THINKING) nPhil[i] = THINKING;
				else if (mPhil[i] == THINKING && rgt == READING) nPhil[i] = READING;
				else if (mPhil[i] == THINKING && hungryReq[i]) nPhil[i] = HUNGRY;
				else if (mPhil[i] == EATING && doneEat[i]) nPhil[i] = THINKING;
				else if (mPhil[i] == HUNGRY && lft != EATING && rgt != HUNGRY &&
						rgt != EATING) nPhil[i] = EATING;
			end
			if (stepNow && mPhil[i] == HUNGRY && mWait[i] == `STARVE_LIMIT - 1 &&
					hitIdx < 0) hitIdx = i;
		end
		@(posedge clk);
		#1;
		// meals land one edge after the transition, a clear drops them
		for (int i = 0; i < `NUM_PHIL; i++) begin
			if (clr) mMeals[i] = 0;
			else if (mPending[i]) mMeals[i] = (mMeals[i] + 1) % (1 << `MEAL_W);
			mPending[i] = stepNow && mPhil[i] == HUNGRY && nPhil[i] == EATING;
			if (clr) mWait[i] = 0;
			else if (stepNow && mPhil[i] != HUNGRY) mWait[i] = 0;
			else if (stepNow && mWait[i] < (1 << `WAIT_W) - 1) mWait[i]++;
		end
		// controller sees the starving flag as it stood before the edge
		case (mCtrl)
			IDLE: if (start) mCtrl = RUN;
			RUN: begin
				if (mStarving) mCtrl = HALTED;
				else if (stop) mCtrl = IDLE;
			end
			default: if (clear) mCtrl = IDLE;
		endcase
		if (clr) begin
			mStarving = 1'b0;
			mIdx = 0;
		end else if (hitIdx >= 0 && !mStarving) begin
			mStarving = 1'b1;
			mIdx = hitIdx;
		end
		mPhil = nPhil;
		cycle++;
		compareAll();
	endtask

	task automatic pulse(input int which);
		if (which == 0) start = 1'b1;
		else if (which == 1) stop = 1'b1;
		else clear = 1'b1;
		tick();
		start = 1'b0;
		stop = 1'b0;
		clear = 1'b0;
	endtask

	task automatic randomInputs();
		hungryReq = $random(seed);
		doneEat = $random(seed) | $random(seed);
	endtask

	task automatic testResetIdle();
		logic [2*`NUM_PHIL-1:0] held;
		compareAll();
		held = philStates;
		for (int n = 0; n < 10; n++) begin
			hungryReq = ~hungryReq;
			tick();
			checkVal("philStates", philStates, held);
		end
	endtask

	task automatic testRandomRun();
		pulse(0);
		for (int n = 0; n < 200; n++) begin
			randomInputs();
			tick();
		end
	endtask

	task automatic testMealCounts();
		if (mCtrl == RUN) pulse(1);
		// let the meals of the last stepped edge land
		repeat (3) tick();
		for (int s = 0; s < `NUM_PHIL; s++) begin
			mealSel = philIdx'(s);
			tick();
			checkVal("mealCountOut", mealCountOut, mealCount'(mMeals[s]));
		end
	endtask

	task automatic testStarvation();
		int starveCycle;
		int extraSteps;
		int n;
		logic [2*`NUM_PHIL-1:0] held;
		if (mCtrl == HALTED) pulse(2);
		if (mCtrl == RUN) pulse(1);
		pulse(0);
		starveCycle = -1;
		extraSteps = 0;
		n = 0;
		while (!halted) begin
			if (n == 1000) begin
				$display("timeout waiting for halted after starvation");
				$display("STATUS: FAIL");
				$fatal(1);
			end
			randomInputs();
			// philosopher 1 eats forever, philosopher 2 keeps asking
			hungryReq[1] = 1'b1;
			hungryReq[2] = 1'b1;
			doneEat[1] = 1'b0;
			doneEat[2] = 1'b1;
			if (starving && mCtrl == RUN) extraSteps++;
			tick();
			if (starving && starveCycle < 0) starveCycle = cycle;
			n++;
		end
		checkVal("haltDelay", cycle - starveCycle, 1);
		checkVal("extraSteps", extraSteps, 1);
		held = philStates;
		for (int k = 0; k < 10; k++) begin
			randomInputs();
			tick();
			checkVal("philStates", philStates, held);
		end
	endtask

	task automatic testClearRestartStop();
		logic [2*`NUM_PHIL-1:0] held;
		pulse(2);
		checkVal("running", running, 1'b0);
		checkVal("halted", halted, 1'b0);
		checkVal("starving", starving, 1'b0);
		pulse(0);
		for (int n = 0; n < 8; n++) begin
			randomInputs();
			tick();
		end
		pulse(1);
		checkVal("running", running, 1'b0);
		held = philStates;
		for (int n = 0; n < 10; n++) begin
			randomInputs();
			tick();
			checkVal("philStates", philStates, held);
		end
		// each restart opens a fresh epoch whatever the previous run counted
		for (int s = 0; s < `NUM_PHIL; s++) begin
			mealSel = philIdx'(s);
			pulse(0);
			checkVal("mealCountOut", mealCountOut, 32'h0);
			pulse(1);
		end
	endtask

	initial begin
		seed = 19;
		cycle = 0;
		arstN = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		clear = 1'b0;
		hungryReq = '0;
		doneEat = '0;
		mealSel = '0;
		modelReset();
		repeat (3) @(posedge clk);
		#1;
		arstN = 1'b1;
		testResetIdle();
		testRandomRun();
		testMealCounts();
		testStarvation();
		testClearRestartStop();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== verif/diners_assertions.sv ====
/*
 * Concurrent checks on the dining philosophers top level.
 * Bound to dinersTop from this file, so the testbench needs no extra wiring.
 */
`timescale 1ns/1ps
`include "diners_params.svh"

module dinersAssertions import dinersPkg::*; (
	input logic                    clk,
	input logic                    arstN,
	input logic                    step,
	input logic                    running,
	input logic                    halted,
	input logic                    starving,
	input logic [2*`NUM_PHIL-1:0]  philStates
);

	// number of failed checks, watched by the testbench
	int failCount = 0;

	// neighbours share a fork, so they never eat together
	genvar i;
	generate
		for (i = 0; i < `NUM_PHIL; i++) begin : gPair
			localparam int nextIdx = (i + 1) % `NUM_PHIL;

			pairNotEating: assert property (@(posedge clk) disable iff (!arstN)
				!((philState'(philStates[2*i +: 2]) == EATING) &&
				  (philState'(philStates[2*nextIdx +: 2]) == EATING)))
				else begin
					failCount++;
					$error("adjacent philosophers %0d and %0d both eating", i, nextIdx);
				end
		end
	endgenerate

	// a halt is only ever caused by starvation and never overlaps a run
	haltedOnStarving: assert property (@(posedge clk) disable iff (!arstN)
		halted |-> (starving && !running))
		else begin
			failCount++;
			$error("halted while running or without starving");
		end

	// an edge without step leaves the ring untouched
	frozenWithoutStep: assert property (@(posedge clk) disable iff (!arstN)
		!step |=> $stable(philStates))
		else begin
			failCount++;
			$error("philStates changed while step was low");
		end

endmodule

bind dinersTop dinersAssertions dinersChk (
	.clk        (clk),
	.arstN      (arstN),
	.step       (step),
	.running    (running),
	.halted     (halted),
	.starving   (starving),
	.philStates (philStates)
);

// ==== verilog/dinersPkg.sv ====
/*
 * Shared types of the dining philosophers design.
 * Modules pull these in with a wildcard import in their header.
 */
`include "diners_params.svh"

package dinersPkg;

	// encoding order follows the original benchmark
	typedef enum logic [1:0] {
		THINKING,
		HUNGRY,
		EATING,
		READING
	} philState;

	// run controller
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HALTED
	} ctrlState;

	typedef logic [`PHIL_IDX_W-1:0] philIdx;
	typedef logic [`WAIT_W-1:0]     waitCount;
	typedef logic [`MEAL_W-1:0]     mealCount;

endpackage

// ==== verilog/dinersTop.sv ====
/*
 * Top level of the dining philosophers table. Connects the run controller,
 * the ring and the starvation and meal monitors.
 */
`timescale 1ns/1ps
`include "diners_params.svh"

module dinersTop import dinersPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    start,
	input  logic                    stop,
	input  logic                    clear,
	input  logic [`NUM_PHIL-1:0]    hungryReq,
	input  logic [`NUM_PHIL-1:0]    doneEat,
	input  philIdx                  mealSel,
	output logic [2*`NUM_PHIL-1:0]  philStates,
	output logic                    running,
	output logic                    halted,
	output logic                    starving,
	output philIdx                  starveIdx,
	output mealCount                mealCountOut
);

	logic step;
	logic clearStats;

	tableController ctrl (
		.clk        (clk),
		.arstN      (arstN),
		.start      (start),
		.stop       (stop),
		.clear      (clear),
		.starving   (starving),
		.step       (step),
		.clearStats (clearStats),
		.running    (running),
		.halted     (halted)
	);

	philRing ring (
		.clk        (clk),
		.arstN      (arstN),
		.step       (step),
		.hungryReq  (hungryReq),
		.doneEat    (doneEat),
		.philStates (philStates)
	);

	// starving feeds back into the controller to halt the run
	starvationMonitor starveMon (
		.clk        (clk),
		.arstN      (arstN),
		.step       (step),
		.clearStats (clearStats),
		.philStates (philStates),
		.starving   (starving),
		.starveIdx  (starveIdx)
	);

	mealCounter meals (
		.clk          (clk),
		.arstN        (arstN),
		.step         (step),
		.clearStats   (clearStats),
		.philStates   (philStates),
		.mealSel      (mealSel),
		.mealCountOut (mealCountOut)
	);

endmodule

// ==== verilog/diners_params.svh ====
/*
 * Sizing constants for the dining philosophers ring.
 * Included by the package and by every module that sizes its ports from them.
 */
`ifndef DINERS_PARAMS_SVH
`define DINERS_PARAMS_SVH

// philosophers in the ring, any value of 3 or more
`define NUM_PHIL 8

// wide enough to index every philosopher
`define PHIL_IDX_W 3

// hungry wait counter, saturates at its maximum
`define WAIT_W 8

// meal counter, wraps around
`define MEAL_W 8

// consecutive stepped cycles spent hungry that count as starvation
`define STARVE_LIMIT 20

`endif

// ==== verilog/mealCounter.sv ====
/*
 * Meal statistics. Counts entries into EATING per philosopher and returns
 * the count of the philosopher picked by mealSel.
 */
`timescale 1ns/1ps
`include "diners_params.svh"

module mealCounter import dinersPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    step,
	input  logic                    clearStats,
	input  logic [2*`NUM_PHIL-1:0]  philStates,
	input  philIdx                  mealSel,
	output mealCount                mealCountOut
);

	mealCount meals [`NUM_PHIL];
	logic [2*`NUM_PHIL-1:0] prevStates;
	logic stepD;
	logic [`NUM_PHIL-1:0] newMeal;

	// snapshot of the states just before each stepped edge
	always_ff @(posedge clk) begin
		if (step) begin
			prevStates <= philStates;
		end
	end

	// marks the cycle right after a stepped edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stepD <= 1'b0;
		end else begin
			stepD <= step;
		end
	end

	always_comb begin
		for (int i = 0; i < `NUM_PHIL; i++) begin
			newMeal[i] = stepD &&
				(philState'(prevStates[2*i +: 2]) == HUNGRY) &&
				(philState'(philStates[2*i +: 2]) == EATING);
		end
	end

	// a meal started at a stepped edge is added at the following edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_PHIL; i++) begin
				meals[i] <= '0;
			end
		end else if (clearStats) begin
			for (int i = 0; i < `NUM_PHIL; i++) begin
				meals[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `NUM_PHIL; i++) begin
				if (newMeal[i]) begin
					meals[i] <= meals[i] + 1'b1;
				end
			end
		end
	end

	// selects past the ring size read as zero
	assign mealCountOut = (mealSel < `NUM_PHIL) ? meals[mealSel] : '0;

endmodule

// ==== verilog/philRing.sv ====
/*
 * Ring of philosophers with modulo neighbour wiring.
 * Philosopher 0 starts READING, all others start THINKING.
 */
`timescale 1ns/1ps
`include "diners_params.svh"

module philRing import dinersPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    step,
	input  logic [`NUM_PHIL-1:0]    hungryReq,
	input  logic [`NUM_PHIL-1:0]    doneEat,
	output logic [2*`NUM_PHIL-1:0]  philStates
);

	philState ringState [`NUM_PHIL];

	genvar i;
	generate
		for (i = 0; i < `NUM_PHIL; i++) begin : gPhil
			// left is i+1, right is i-1, both wrapping around the table
			localparam int leftIdx  = (i + 1) % `NUM_PHIL;
			localparam int rightIdx = (i + `NUM_PHIL - 1) % `NUM_PHIL;

			philosopher #(
				.initState((i == 0) ? READING : THINKING)
			) phil (
				.clk       (clk),
				.arstN     (arstN),
				.step      (step),
				.left      (ringState[leftIdx]),
				.right     (ringState[rightIdx]),
				.hungryReq (hungryReq[i]),
				.doneEat   (doneEat[i]),
				.state     (ringState[i])
			);

			// philosopher i sits at bits 2i+1 down to 2i
			assign philStates[2*i +: 2] = ringState[i];
		end
	endgenerate

endmodule

// ==== verilog/philosopher.sv ====
/*
 * One philosopher of the ring. Reacts to its left and right neighbours and
 * to its own hunger request and done strobe, on stepped edges only.
 */
`timescale 1ns/1ps

module philosopher import dinersPkg::*; #(
	parameter philState initState = THINKING
) (
	input  logic     clk,
	input  logic     arstN,
	input  logic     step,
	input  philState left,
	input  philState right,
	input  logic     hungryReq,
	input  logic     doneEat,
	output philState state
);

	philState nextState;

	// neighbour values are the ones registered before this edge
	always_comb begin
		nextState = state;
		case (state)
			READING: begin
				if (left == THINKING) begin
					nextState = THINKING;
				end
			end
			THINKING: begin
				// reading right neighbour wins over our own hunger
				if (right == READING) begin
					nextState = READING;
				end else if (hungryReq) begin
					nextState = HUNGRY;
				end
			end
			EATING: begin
				if (doneEat) begin
					nextState = THINKING;
				end
			end
			HUNGRY: begin
				// left must not hold the fork, right must be neither waiting nor eating
				if (left != EATING && right != HUNGRY && right != EATING) begin
					nextState = EATING;
				end
			end
			default: begin
				nextState = initState;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= initState;
		end else if (step) begin
			state <= nextState;
		end
	end

endmodule

// ==== verilog/starvationMonitor.sv ====
/*
 * Hungry wait counters per philosopher. Raises a sticky starving flag when a
 * counter reaches the limit and captures the lowest index that got there.
 */
`timescale 1ns/1ps
`include "diners_params.svh"

module starvationMonitor import dinersPkg::*; (
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    step,
	input  logic                    clearStats,
	input  logic [2*`NUM_PHIL-1:0]  philStates,
	output logic                    starving,
	output philIdx                  starveIdx
);

	waitCount waitCnt [`NUM_PHIL];
	logic [`NUM_PHIL-1:0] hungry;
	logic [`NUM_PHIL-1:0] limitHit;
	logic hitAny;
	philIdx hitIdx;

	// a hit means the counter becomes STARVE_LIMIT at this stepped edge
	always_comb begin
		for (int i = 0; i < `NUM_PHIL; i++) begin
			hungry[i]   = (philState'(philStates[2*i +: 2]) == HUNGRY);
			limitHit[i] = step && hungry[i] &&
				(waitCnt[i] == waitCount'(`STARVE_LIMIT - 1));
		end
	end

	// lowest index wins, so scan from the top down
	always_comb begin
		hitAny = |limitHit;
		hitIdx = '0;
		for (int i = `NUM_PHIL - 1; i >= 0; i--) begin
			if (limitHit[i]) begin
				hitIdx = philIdx'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_PHIL; i++) begin
				waitCnt[i] <= '0;
			end
		end else if (clearStats) begin
			for (int i = 0; i < `NUM_PHIL; i++) begin
				waitCnt[i] <= '0;
			end
		end else if (step) begin
			for (int i = 0; i < `NUM_PHIL; i++) begin
				if (!hungry[i]) begin
					waitCnt[i] <= '0;
				end else if (waitCnt[i] != '1) begin
					// saturate instead of wrapping back below the limit
					waitCnt[i] <= waitCnt[i] + 1'b1;
				end
			end
		end
	end

	// first starving philosopher of the epoch is kept
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			starving  <= 1'b0;
			starveIdx <= '0;
		end else if (clearStats) begin
			starving  <= 1'b0;
			starveIdx <= '0;
		end else if (hitAny && !starving) begin
			starving  <= 1'b1;
			starveIdx <= hitIdx;
		end
	end

endmodule

// ==== verilog/tableController.sv ====
/*
 * Run controller of the table. Produces the step enable that gates the ring
 * and the monitors, and the clear pulse that opens a new statistics epoch.
 */
`timescale 1ns/1ps

module tableController import dinersPkg::*; (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  logic stop,
	input  logic clear,
	input  logic starving,
	output logic step,
	output logic clearStats,
	output logic running,
	output logic halted
);

	ctrlState state;
	ctrlState nextState;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (start) begin
					nextState = RUN;
				end
			end
			RUN: begin
				// starvation takes precedence over a stop in the same cycle
				if (starving) begin
					nextState = HALTED;
				end else if (stop) begin
					nextState = IDLE;
				end
			end
			HALTED: begin
				if (clear) begin
					nextState = IDLE;
				end
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// all decoded straight from the state register
	assign running = (state == RUN);
	assign halted  = (state == HALTED);
	assign step    = (state == RUN);

	// fresh epoch when a run starts and when a halt is cleared
	assign clearStats = (state == IDLE && start) || (state == HALTED && clear);

endmodule
